// ==== testbench/bowling_vectors.txt ====
# name op addr wdata exp_prdata exp_pslverr, numbers in hex
# op W writes, R reads and compares, P polls STATUS until rolling is 0
reset_status   R 08 00000000 03FF0000 0
reset_score    R 0C 00000000 00000000 0
center_launch  W 00 040000DC 00000000 0
center_wait    P 08 00000000 00000000 0
center_status  R 08 00000000 03240060 0
center_score   R 0C 00000000 00000006 0
gutter_launch  W 00 0107012C 00000000 0
gutter_wait    P 08 00000000 00000000 0
gutter_status  R 08 00000000 03240000 0
gutter_score   R 0C 00000000 00000006 0
right_launch   W 00 050000F9 00000000 0
busy_launch    W 00 040000DC 00000000 1
right_wait     P 08 00000000 00000000 0
right_status   R 08 00000000 01040020 0
right_score    R 0C 00000000 00000008 0
vy_zero        W 00 000000DC 00000000 1
vy_negative    W 00 0F0000DC 00000000 1
idle_status    R 08 00000000 01040020 0
bad_addr_read  R 10 00000000 00000000 1
launch_read    R 00 00000000 00000000 0
rack_write     W 04 00000000 00000000 0
rack_status    R 08 00000000 03FF0020 0
rack_score     R 0C 00000000 00000000 0
strike_launch  W 00 040000E8 00000000 0
strike_wait    P 08 00000000 00000000 0
strike_status  R 08 00000000 000000A2 0
strike_score   R 0C 00000000 0000000A 0

// ==== bowling_core.f ====
verilog/bowling_pkg.sv
verilog/bowling_regs_pkg.sv
verilog/apb_launch_regs.sv
verilog/ball_kinematics.sv
verilog/pin_rack.sv
verilog/roll_scorer.sv
verilog/bowling_core.sv
testbench/bowling_checker.sv
testbench/tb_bowling_core.sv

// ==== Makefile ====
TOP := tb_bowling_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f bowling_core.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

// ==== testbench/tb_bowling_core.sv ====
`timescale 1ns/10ps

module tb_bowling_core;

  localparam int MAX_VECTORS = 64;
  localparam int RESET_CYCLES = 10;
  localparam int ROLL_CYCLES = bowling_pkg::START_Y * bowling_pkg::STEP_CYCLES + 100;

  logic clk_in;
  logic arst_n;
  bowling_regs_pkg::apb_req_t apb_req;
  bowling_regs_pkg::apb_rsp_t apb_rsp;

  // expectation handed to the checker during the access cycle
  logic check_en;
  logic [8*16-1:0] check_name;
  bowling_regs_pkg::word_t exp_prdata;
  logic exp_pslverr;
  int check_errors;

  logic [8*16-1:0] vec_name [MAX_VECTORS];
  logic [7:0] vec_op [MAX_VECTORS];       // W, R or P
  bowling_regs_pkg::paddr_t vec_addr [MAX_VECTORS];
  bowling_regs_pkg::word_t vec_wdata [MAX_VECTORS];
  bowling_regs_pkg::word_t vec_prdata [MAX_VECTORS];
  logic vec_pslverr [MAX_VECTORS];
  int num_vectors;
  logic vectors_loaded;
  int poll_errors;
  int file_errors;

  always #10 clk_in = ~clk_in;  // 20 ns period

  bowling_core u_bowling_core (
    .clk_in  (clk_in),
    .arst_n  (arst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  bowling_checker u_bowling_checker (
    .clk_in      (clk_in),
    .arst_n      (arst_n),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .check_en    (check_en),
    .check_name  (check_name),
    .exp_prdata  (exp_prdata),
    .exp_pslverr (exp_pslverr),
    .error_count (check_errors)
  );

  task automatic load_vectors();
    int fd;
    int n;
    string line;
    logic [8*16-1:0] name;
    logic [7:0] op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] prdata;
    logic [31:0] err;
    fd = $fopen("testbench/bowling_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open testbench/bowling_vectors.txt");
      file_errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n == 0 || line.len() < 2 || line.getc(0) == "#") continue;  // blank or column notes
      n = $sscanf(line, "%s %s %h %h %h %h", name, op, addr, wdata, prdata, err);
      if (n != 6 || num_vectors == MAX_VECTORS) begin
        $display("vector line skipped, bad format or table full: %s", line);
        file_errors++;
        continue;
      end
      vec_name[num_vectors] = name;
      vec_op[num_vectors] = op;
      vec_addr[num_vectors] = addr[7:0];
      vec_wdata[num_vectors] = wdata;
      vec_prdata[num_vectors] = prdata;
      vec_pslverr[num_vectors] = err[0];
      num_vectors++;
    end
    $fclose(fd);
  endtask

  // setup, access, then back to idle; read data is taken mid access cycle
  task automatic apb_transfer(input logic write, input bowling_regs_pkg::paddr_t addr,
                              input bowling_regs_pkg::word_t wdata, input logic check,
                              input logic [8*16-1:0] name,
                              input bowling_regs_pkg::word_t exp_data, input logic exp_err,
                              output bowling_regs_pkg::word_t rdata);
    @(posedge clk_in);
    #2;
    apb_req.psel = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite = write;
    apb_req.paddr = addr;
    apb_req.pwdata = wdata;
    @(posedge clk_in);
    #2;
    apb_req.penable = 1'b1;
    check_en = check;
    check_name = name;
    exp_prdata = exp_data;
    exp_pslverr = exp_err;
    @(negedge clk_in);
    rdata = apb_rsp.prdata;
    @(posedge clk_in);
    #2;
    apb_req = '0;
    check_en = 1'b0;
  endtask

  task automatic poll_idle(input logic [8*16-1:0] name);
    bowling_regs_pkg::word_t status;
    int waited;
    waited = 0;
    status = '1;  // counts as rolling until the first read
    while (status[bowling_regs_pkg::STATUS_ROLLING_BIT] && waited <= ROLL_CYCLES) begin
      apb_transfer(1'b0, bowling_regs_pkg::ADDR_STATUS, '0, 1'b0, name, '0, 1'b0, status);
      waited += 3;
    end
    if (status[bowling_regs_pkg::STATUS_ROLLING_BIT]) begin
      $display("%0s: STATUS still shows a roll in progress after %0d cycles", name, waited);
      poll_errors++;
    end
  endtask

  initial begin
    bowling_regs_pkg::word_t rdata;
    clk_in = 1'b0;
    arst_n = 1'b0;
    apb_req = '0;
    check_en = 1'b0;
    check_name = '0;
    exp_prdata = '0;
    exp_pslverr = 1'b0;
    num_vectors = 0;
    poll_errors = 0;
    file_errors = 0;
    vectors_loaded = 1'b0;
    load_vectors();
    vectors_loaded = 1'b1;
    if (num_vectors == 0) begin
      $display("no vectors were loaded");
      file_errors++;
    end
    repeat (RESET_CYCLES) @(posedge clk_in);
    #2;
    arst_n = 1'b1;
    for (int i = 0; i < num_vectors; i++) begin
      case (vec_op[i])
        "W": apb_transfer(1'b1, vec_addr[i], vec_wdata[i], 1'b1, vec_name[i],
                          vec_prdata[i], vec_pslverr[i], rdata);
        "R": apb_transfer(1'b0, vec_addr[i], vec_wdata[i], 1'b1, vec_name[i],
                          vec_prdata[i], vec_pslverr[i], rdata);
        "P": poll_idle(vec_name[i]);
        default: begin
          $display("%0s: unknown operation in vector file", vec_name[i]);
          file_errors++;
        end
      endcase
    end
    repeat (2) @(posedge clk_in);
    $display("errors: %0d check, %0d poll, %0d vector file",
             check_errors, poll_errors, file_errors);
    if (check_errors + poll_errors + file_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // watchdog sized from the vector count
  initial begin
    int limit;
    wait (vectors_loaded);
    limit = (num_vectors + 1) * ROLL_CYCLES + RESET_CYCLES;
    repeat (limit) @(posedge clk_in);
    $display("watchdog expired after %0d cycles, the run never reached its end", limit);
    $display("tests failed");
    $finish;
  end

endmodule

// ==== testbench/bowling_checker.sv ====
`timescale 1ns/10ps

module bowling_checker (
  input  logic                       clk_in,
  input  logic                       arst_n,
  input  bowling_regs_pkg::apb_req_t apb_req,
  input  bowling_regs_pkg::apb_rsp_t apb_rsp,
  input  logic                       check_en,
  input  logic [8*16-1:0]            check_name,
  input  bowling_regs_pkg::word_t    exp_prdata,
  input  logic                       exp_pslverr,
  output int                         error_count
);

  bowling_pkg::pin_mask_t exp_mask;
  bowling_pkg::pin_mask_t act_mask;
  bowling_pkg::pin_count_t exp_pins;
  bowling_pkg::pin_count_t act_pins;
  logic failed;

  assign exp_mask = exp_prdata[bowling_regs_pkg::STATUS_MASK_MSB:bowling_regs_pkg::STATUS_MASK_LSB];
  assign act_mask = apb_rsp.prdata[bowling_regs_pkg::STATUS_MASK_MSB:
                                   bowling_regs_pkg::STATUS_MASK_LSB];
  assign exp_pins = exp_prdata[bowling_regs_pkg::STATUS_PINS_MSB:bowling_regs_pkg::STATUS_PINS_LSB];
  assign act_pins = apb_rsp.prdata[bowling_regs_pkg::STATUS_PINS_MSB:
                                   bowling_regs_pkg::STATUS_PINS_LSB];

  initial begin
    error_count = 0;
  end

  // field view of a wrong STATUS word
  task automatic show_status_fields();
    $display("  standing expected %b actual %b", exp_mask, act_mask);
    $display("  pins expected %0d actual %0d, strike expected %0b actual %0b",
             exp_pins, act_pins,
             exp_prdata[bowling_regs_pkg::STATUS_STRIKE_BIT],
             apb_rsp.prdata[bowling_regs_pkg::STATUS_STRIKE_BIT]);
  endtask

  // inputs change 2 ns after the edge, so mid cycle is stable
  always @(negedge clk_in) begin
    if (arst_n && check_en) begin
      failed = 1'b0;
      if (apb_rsp.pready !== 1'b1) begin
        $display("%0s: pready was low in the access phase", check_name);
        failed = 1'b1;
      end
      if (apb_rsp.pslverr !== exp_pslverr) begin
        $display("** Error %0s expected pslverr %0b actual %0b",
                 check_name, exp_pslverr, apb_rsp.pslverr);
        failed = 1'b1;
      end
      if (!apb_req.pwrite && (apb_rsp.prdata !== exp_prdata)) begin
        $display("** Error %0s expected %h actual %h", check_name, exp_prdata, apb_rsp.prdata);
        if (apb_req.paddr == bowling_regs_pkg::ADDR_STATUS) show_status_fields();
        failed = 1'b1;
      end
      if (failed) error_count++;
    end
  end

endmodule

// ==== verilog/bowling_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module bowling_core (
  input  wire                             clk_in,
  input  wire                             arst_n,
  input  wire bowling_regs_pkg::apb_req_t apb_req,
  output bowling_regs_pkg::apb_rsp_t      apb_rsp
);

  bowling_pkg::launch_cmd_t launch;
  logic rack_clear;
  bowling_pkg::ball_state_t ball;
  bowling_pkg::pin_mask_t standing;
  bowling_pkg::pin_count_t last_pins;
  logic strike;
  bowling_pkg::score_t total;
  logic rolling;  // held until the score is in

  apb_launch_regs u_apb_launch_regs (
    .clk_in     (clk_in),
    .arst_n     (arst_n),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .rolling    (rolling),
    .standing   (standing),
    .last_pins  (last_pins),
    .strike     (strike),
    .total      (total),
    .launch     (launch),
    .rack_clear (rack_clear)
  );

  ball_kinematics u_ball_kinematics (
    .clk_in (clk_in),
    .arst_n (arst_n),
    .launch (launch),
    .ball   (ball)
  );

  // rack follows the ball each step
  pin_rack u_pin_rack (
    .clk_in     (clk_in),
    .arst_n     (arst_n),
    .ball       (ball),
    .rack_clear (rack_clear),
    .standing   (standing)
  );

  roll_scorer u_roll_scorer (
    .clk_in     (clk_in),
    .arst_n     (arst_n),
    .ball       (ball),
    .standing   (standing),
    .rack_clear (rack_clear),
    .last_pins  (last_pins),
    .strike     (strike),
    .total      (total),
    .rolling    (rolling)
  );

endmodule

`default_nettype wire

// ==== verilog/roll_scorer.sv ====
`timescale 1ns/10ps
`default_nettype none

module roll_scorer (
  input  wire                           clk_in,
  input  wire                           arst_n,
  input  wire bowling_pkg::ball_state_t ball,
  input  wire bowling_pkg::pin_mask_t   standing,
  input  wire                           rack_clear,
  output bowling_pkg::pin_count_t       last_pins,
  output logic                          strike,
  output bowling_pkg::score_t           total,
  output logic                          rolling
);

  bowling_pkg::pin_count_t up_count;
  bowling_pkg::pin_count_t snap_q;   // pins up when the roll started
  bowling_pkg::pin_count_t knocked;
  logic busy_q;
  logic done_q;

  assign up_count = bowling_pkg::pin_count_t'($countones(standing));
  assign knocked = snap_q - up_count;

  // covers the gap between ball done and the score update
  assign rolling = ball.rolling || busy_q;

  always_ff @(posedge clk_in) begin
    if (ball.rolling && !busy_q) snap_q <= up_count;  // first rolling cycle
  end

  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      last_pins <= '0;
      strike <= 1'b0;
      total <= '0;
    end else begin
      done_q <= ball.done;  // last mask update has landed by now

      if (ball.rolling) busy_q <= 1'b1;
      else if (done_q) busy_q <= 1'b0;

      if (rack_clear) begin
        strike <= 1'b0;
        total <= '0;
      end else if (done_q) begin
        last_pins <= knocked;
        strike <= (int'(snap_q) == bowling_pkg::NUM_PINS) &&
                  (int'(knocked) == bowling_pkg::NUM_PINS);
        total <= total + bowling_pkg::score_t'(knocked);
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/pin_rack.sv ====
`timescale 1ns/10ps
`default_nettype none

module pin_rack (
  input  wire                           clk_in,
  input  wire                           arst_n,
  input  wire bowling_pkg::ball_state_t ball,
  input  wire                           rack_clear,
  output bowling_pkg::pin_mask_t        standing
);

  bowling_pkg::pin_mask_t hit;
  logic [bowling_pkg::NUM_PINS-1:0] x_overlap;
  logic [bowling_pkg::NUM_PINS-1:0] y_overlap;

  // box test of the ball against every pin
  always_comb begin
    for (int i = 0; i < bowling_pkg::NUM_PINS; i++) begin
      x_overlap[i] = (int'(ball.x) < bowling_pkg::PIN_X[i] + bowling_pkg::PIN_SIZE) &&
                     (bowling_pkg::PIN_X[i] < int'(ball.x) + bowling_pkg::BALL_SIZE);
      y_overlap[i] = (int'(ball.y) < bowling_pkg::PIN_Y[i] + bowling_pkg::PIN_SIZE) &&
                     (bowling_pkg::PIN_Y[i] < int'(ball.y) + bowling_pkg::BALL_SIZE);
      hit[i] = x_overlap[i] && y_overlap[i];
    end
  end

  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      standing <= '1;
    end else if (rack_clear) begin
      standing <= '1;  // fresh rack
    end else if (ball.moved) begin
      standing <= standing & ~hit;  // fallen pins stay down
    end
  end

  // only a rolling ball takes steps that can knock pins
  assert property (@(posedge clk_in) disable iff (!arst_n)
    ball.moved |-> ball.rolling)
    else $error("ball stepped while not rolling");

endmodule

`default_nettype wire

// ==== verilog/ball_kinematics.sv ====
`timescale 1ns/10ps
`default_nettype none

module ball_kinematics (
  input  wire                           clk_in,
  input  wire                           arst_n,
  input  wire bowling_pkg::launch_cmd_t launch,
  output bowling_pkg::ball_state_t      ball
);

  typedef enum logic [1:0] {
    IDLE,
    ROLL,
    DONE
  } state_t;

  state_t state;
  logic [$clog2(bowling_pkg::STEP_CYCLES)-1:0] step_cnt;
  logic moved_q;
  logic gutter;
  logic lane_end;
  logic roll_end;
  logic step_fire;

  bowling_pkg::coord_x_t x_q;
  bowling_pkg::coord_y_t y_q;
  bowling_pkg::vel_t vx_q;
  bowling_pkg::vel_t vy_q;

  // only tested on the new position right after a step
  assign gutter = (int'(x_q) < bowling_pkg::LANE_LEFT) ||
                  (int'(x_q) + bowling_pkg::BALL_SIZE > bowling_pkg::LANE_RIGHT);
  assign lane_end = int'(y_q) <= bowling_pkg::LANE_END_Y;
  assign roll_end = moved_q && (gutter || lane_end);

  assign step_fire = (state == ROLL) && !roll_end &&
                     (int'(step_cnt) == bowling_pkg::STEP_CYCLES - 1);

  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
      step_cnt <= '0;
      moved_q <= 1'b0;
    end else begin
      moved_q <= step_fire;
      case (state)
        IDLE: begin
          step_cnt <= '0;
          if (launch.valid) state <= ROLL;
        end
        ROLL: begin
          if (roll_end) state <= DONE;
          else if (step_fire) step_cnt <= '0;
          else step_cnt <= step_cnt + 1'b1;
        end
        default: state <= IDLE;  // DONE lasts one cycle
      endcase
    end
  end

  // position and velocity, loaded at launch
  always_ff @(posedge clk_in) begin
    if ((state == IDLE) && launch.valid) begin
      x_q <= launch.x;
      y_q <= bowling_pkg::coord_y_t'(bowling_pkg::START_Y);
      vx_q <= launch.vx;
      vy_q <= launch.vy;
    end else if (step_fire) begin
      x_q <= x_q + {{7{vx_q[3]}}, vx_q};  // sign extend to 11 bits
      y_q <= y_q - {{6{vy_q[3]}}, vy_q};  // y counts down the lane
    end
  end

  assign ball = '{x: x_q, y: y_q, moved: moved_q,
                  rolling: (state == ROLL), done: (state == DONE)};

  // every step carries the ball further down the lane
  assert property (@(posedge clk_in) disable iff (!arst_n)
    ball.moved |-> (ball.y < $past(ball.y)))
    else $error("ball step did not move down the lane");

endmodule

`default_nettype wire

// ==== verilog/apb_launch_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module apb_launch_regs (
  input  wire                            clk_in,
  input  wire                            arst_n,
  input  wire bowling_regs_pkg::apb_req_t apb_req,
  output bowling_regs_pkg::apb_rsp_t     apb_rsp,
  input  wire                            rolling,
  input  wire bowling_pkg::pin_mask_t    standing,
  input  wire bowling_pkg::pin_count_t   last_pins,
  input  wire                            strike,
  input  wire bowling_pkg::score_t       total,
  output bowling_pkg::launch_cmd_t       launch,
  output logic                           rack_clear
);

  logic access;       // APB access phase
  logic addr_known;
  logic launch_bad;   // busy or vy not positive
  logic wr_launch;
  logic wr_rack;
  bowling_pkg::vel_t wr_vy;
  bowling_regs_pkg::word_t status_word;

  logic launch_valid_q;
  bowling_pkg::coord_x_t launch_x_q;
  bowling_pkg::vel_t launch_vx_q;
  bowling_pkg::vel_t launch_vy_q;
  logic rack_clear_q;

  assign access = apb_req.psel && apb_req.penable;
  assign addr_known = apb_req.paddr inside {bowling_regs_pkg::ADDR_LAUNCH,
                                            bowling_regs_pkg::ADDR_RACK,
                                            bowling_regs_pkg::ADDR_STATUS,
                                            bowling_regs_pkg::ADDR_SCORE};

  assign wr_vy = bowling_pkg::vel_t'(
    apb_req.pwdata[bowling_regs_pkg::LAUNCH_VY_MSB:bowling_regs_pkg::LAUNCH_VY_LSB]);

  // one roll at a time, and the ball has to head down the lane
  assign launch_bad = apb_req.pwrite && (apb_req.paddr == bowling_regs_pkg::ADDR_LAUNCH) &&
                      (rolling || (wr_vy == '0) || wr_vy[3]);

  assign wr_launch = access && apb_req.pwrite && !launch_bad &&
                     (apb_req.paddr == bowling_regs_pkg::ADDR_LAUNCH);
  assign wr_rack = access && apb_req.pwrite && (apb_req.paddr == bowling_regs_pkg::ADDR_RACK);

  always_comb begin
    status_word = '0;
    status_word[bowling_regs_pkg::STATUS_ROLLING_BIT] = rolling;
    status_word[bowling_regs_pkg::STATUS_STRIKE_BIT] = strike;
    status_word[bowling_regs_pkg::STATUS_PINS_MSB:bowling_regs_pkg::STATUS_PINS_LSB] = last_pins;
    status_word[bowling_regs_pkg::STATUS_MASK_MSB:bowling_regs_pkg::STATUS_MASK_LSB] = standing;
  end

  always_comb begin
    apb_rsp.pready = 1'b1;  // no wait states
    apb_rsp.pslverr = access && (launch_bad || !addr_known);
    apb_rsp.prdata = '0;
    if (access && !apb_req.pwrite) begin
      case (apb_req.paddr)
        bowling_regs_pkg::ADDR_STATUS: apb_rsp.prdata = status_word;
        bowling_regs_pkg::ADDR_SCORE:  apb_rsp.prdata = bowling_regs_pkg::word_t'(total);
        default:                       apb_rsp.prdata = '0;  // write-only or unmapped
      endcase
    end
  end

  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      launch_valid_q <= 1'b0;
      rack_clear_q <= 1'b0;
    end else begin
      launch_valid_q <= wr_launch;
      rack_clear_q <= wr_rack;
    end
  end

  always_ff @(posedge clk_in) begin
    if (wr_launch) begin
      launch_x_q <= apb_req.pwdata[bowling_regs_pkg::LAUNCH_X_MSB:bowling_regs_pkg::LAUNCH_X_LSB];
      launch_vx_q <= apb_req.pwdata[bowling_regs_pkg::LAUNCH_VX_MSB:bowling_regs_pkg::LAUNCH_VX_LSB];
      launch_vy_q <= wr_vy;
    end
  end

  assign launch = '{valid: launch_valid_q, x: launch_x_q, vx: launch_vx_q, vy: launch_vy_q};
  assign rack_clear = rack_clear_q;

  // a launch only goes out while no roll is in flight
  assert property (@(posedge clk_in) disable iff (!arst_n)
    launch.valid |-> !rolling)
    else $error("launch issued while a roll is in progress");

endmodule

`default_nettype wire

// ==== verilog/bowling_regs_pkg.sv ====
package bowling_regs_pkg;

  typedef logic [7:0] paddr_t;
  typedef logic [31:0] word_t;

  typedef struct packed {
    logic   psel;
    logic   penable;
    logic   pwrite;
    paddr_t paddr;
    word_t  pwdata;
  } apb_req_t;

  typedef struct packed {
    word_t prdata;
    logic  pready;
    logic  pslverr;
  } apb_rsp_t;

  localparam paddr_t ADDR_LAUNCH = 8'h00;  // write only
  localparam paddr_t ADDR_RACK = 8'h04;    // write only
  localparam paddr_t ADDR_STATUS = 8'h08;  // read only
  localparam paddr_t ADDR_SCORE = 8'h0C;   // read only

  // launch word
  localparam int LAUNCH_X_LSB = 0;
  localparam int LAUNCH_X_MSB = 10;
  localparam int LAUNCH_VX_LSB = 16;
  localparam int LAUNCH_VX_MSB = 19;
  localparam int LAUNCH_VY_LSB = 24;
  localparam int LAUNCH_VY_MSB = 27;

  // status word
  localparam int STATUS_ROLLING_BIT = 0;
  localparam int STATUS_STRIKE_BIT = 1;
  localparam int STATUS_PINS_LSB = 4;
  localparam int STATUS_PINS_MSB = 7;
  localparam int STATUS_MASK_LSB = 16;
  localparam int STATUS_MASK_MSB = 25;

endpackage

// ==== verilog/bowling_pkg.sv ====
package bowling_pkg;

  localparam int NUM_PINS = 10;

  typedef logic [10:0] coord_x_t;           // lane column in pixels
  typedef logic [9:0] coord_y_t;            // lane row, smaller is further down the lane
  typedef logic signed [3:0] vel_t;         // pixels per step
  typedef logic [NUM_PINS-1:0] pin_mask_t;  // bit set while that pin stands
  typedef logic [3:0] pin_count_t;
  typedef logic [8:0] score_t;

  // lane geometry in pixels
  localparam int LANE_LEFT = 100;
  localparam int LANE_RIGHT = 356;          // box right edge may touch but not pass
  localparam int START_Y = 460;
  localparam int LANE_END_Y = 40;
  localparam int BALL_SIZE = 16;
  localparam int PIN_SIZE = 10;
  localparam int STEP_CYCLES = 4;           // clocks per ball move

  // top-left corners of the rack
  // pin 0 is the head pin nearest the bowler, then rows of 2, 3 and 4
  // further down the lane, each row ordered left to right
  localparam int PIN_X [NUM_PINS] = '{
    235,
    232, 238,
    229, 235, 241,
    226, 232, 238, 244
  };
  localparam int PIN_Y [NUM_PINS] = '{
    150,
    136, 136,
    122, 122, 122,
    108, 108, 108, 108
  };

  typedef struct packed {
    logic     valid;   // one cycle pulse
    coord_x_t x;
    vel_t     vx;
    vel_t     vy;
  } launch_cmd_t;

  typedef struct packed {
    coord_x_t x;
    coord_y_t y;
    logic     moved;   // pulse after each step
    logic     rolling;
    logic     done;    // pulse at roll end
  } ball_state_t;

endpackage
